/* src.f */
src/eeprom_pkg.sv
src/eeprom_req_if.sv
src/eeprom_arbiter.sv
src/eeprom_serial_ctrl.sv
src/eeprom_sys_top.sv
tb/eeprom_model.sv
tb/tb_eeprom_sys.sv

/* Makefile */
TOP := tb_eeprom_sys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module eeprom_sys_top
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* tb/tb_eeprom_sys.sv */
`timescale 1ns/1ps

module tb_eeprom_sys import eeprom_pkg::*; ();

    localparam int NUM_OPS = 100;   // per port

    logic         CLK;
    logic         RESET;
    logic         a_wr, a_rd, b_wr, b_rd;
    eeprom_addr_t a_addr, b_addr;
    eeprom_data_t a_wdata, b_wdata;
    logic         a_done, b_done;
    eeprom_data_t a_rdata, b_rdata;
    logic         scl, sda_oe, sda_in, proto_err;

    eeprom_data_t ref_mem  [2048];
    logic         op_rd    [NUM_PORTS][NUM_OPS];
    eeprom_addr_t op_addr  [NUM_PORTS][NUM_OPS];
    eeprom_data_t op_data  [NUM_PORTS][NUM_OPS];
    int           op_gap   [NUM_PORTS][NUM_OPS];
    int           done_cnt [NUM_PORTS];
    int           exp_cnt  [NUM_PORTS];

    eeprom_sys_top DUT
    (
        .CLK(CLK), .RESET(RESET),
        .a_wr(a_wr), .a_rd(a_rd), .a_addr(a_addr), .a_wdata(a_wdata),
        .a_done(a_done), .a_rdata(a_rdata),
        .b_wr(b_wr), .b_rd(b_rd), .b_addr(b_addr), .b_wdata(b_wdata),
        .b_done(b_done), .b_rdata(b_rdata),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

    eeprom_model u_model (.scl(scl), .sda_oe(sda_oe), .sda_in(sda_in), .proto_err(proto_err));

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check_data(input string name, input eeprom_data_t got, input eeprom_data_t exp);
        if (got !== exp)
        begin
            $display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    always @(negedge CLK)
    begin
        if (a_done === 1'b1) done_cnt[0]++;
        if (b_done === 1'b1) done_cnt[1]++;
        if (proto_err === 1'b1)
            check_flag("proto_err", proto_err, 1'b0);   // bus error seen by the slave
    end

    task automatic send(input port_id_t p, input logic rd, input eeprom_addr_t addr,
                        input eeprom_data_t data);
        @(posedge CLK);
        if (p == 1'b0)
        begin
            a_wr <= !rd;
            a_rd <= rd;
            a_addr <= addr;
            a_wdata <= data;
        end
        else
        begin
            b_wr <= !rd;
            b_rd <= rd;
            b_addr <= addr;
            b_wdata <= data;
        end
        @(posedge CLK);
        if (p == 1'b0)
        begin
            a_wr <= 1'b0;
            a_rd <= 1'b0;
        end
        else
        begin
            b_wr <= 1'b0;
            b_rd <= 1'b0;
        end
    endtask

    task automatic wait_done(input port_id_t p, output eeprom_data_t rdata);
        int n;
        for (n = 0; n < 2000; n++)
        begin
            @(negedge CLK);
            if ((p == 1'b0 && a_done) || (p == 1'b1 && b_done))
                break;
        end
        if (n == 2000)
        begin
            $display("timeout waiting for done on port %0d at %0t", p, $time);
            $display("Checks failed");
            $fatal(1);
        end
        rdata = (p == 1'b0) ? a_rdata : b_rdata;
    endtask

    // reference updated or compared at the done of each transaction
    task automatic do_op(input port_id_t p, input logic rd, input eeprom_addr_t addr,
                         input eeprom_data_t data);
        eeprom_data_t rdata;
        send(p, rd, addr, data);
        exp_cnt[p]++;
        wait_done(p, rdata);
        if (rd)
            check_data(p ? "b_rdata" : "a_rdata", rdata, ref_mem[addr]);
        else
            ref_mem[addr] = data;
    endtask

    task automatic run_port(input port_id_t p);
        for (int i = 0; i < NUM_OPS; i++)
        begin
            repeat (op_gap[p][i]) @(posedge CLK);
            do_op(p, op_rd[p][i], op_addr[p][i], op_data[p][i]);
        end
    endtask

    initial
    begin
        eeprom_data_t d1;
        eeprom_data_t d2;
        void'($urandom(32'h5576_b343));
        RESET = 1'b1;
        a_wr = 1'b0;
        a_rd = 1'b0;
        a_addr = '0;
        a_wdata = '0;
        b_wr = 1'b0;
        b_rd = 1'b0;
        b_addr = '0;
        b_wdata = '0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = ERASED_BYTE;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            done_cnt[p] = 0;
            exp_cnt[p]  = 0;
            for (int i = 0; i < NUM_OPS; i++)
            begin
                op_rd[p][i]   = $urandom % 2;
                op_addr[p][i] = ($urandom % 6) * 11'h155;   // six addresses, all high bits
                op_data[p][i] = $urandom;
                op_gap[p][i]  = $urandom % 40;
            end
        end
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_oe", sda_oe, 1'b0);
        check_flag("a_done", a_done, 1'b0);
        check_flag("b_done", b_done, 1'b0);

        d1 = $urandom;
        do_op(1'b0, 1'b0, 11'h123, d1);
        do_op(1'b0, 1'b1, 11'h123, 8'h00);
        do_op(1'b0, 1'b1, 11'h7fe, 8'h00);   // never written

        // both ports in the same cycle
        d1 = $urandom;
        d2 = $urandom;
        fork
            do_op(1'b0, 1'b0, 11'h2a1, d1);
            do_op(1'b1, 1'b0, 11'h51c, d2);
        join
        fork
            do_op(1'b0, 1'b1, 11'h51c, 8'h00);
            do_op(1'b1, 1'b1, 11'h2a1, 8'h00);
        join

        fork
            run_port(1'b0);
            run_port(1'b1);
        join
        repeat (10) @(negedge CLK);
        check_flag("a_done count", done_cnt[0] == exp_cnt[0], 1'b1);
        check_flag("b_done count", done_cnt[1] == exp_cnt[1], 1'b1);
        check_flag("proto_err", proto_err, 1'b0);
        $display("All checks passed");
        $finish;
    end

endmodule

/* tb/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda_oe,
    output logic sda_in,
    output logic proto_err
);

    eeprom_data_t mem [2048];
    eeprom_data_t shift;
    eeprom_data_t wdata;
    eeprom_addr_t addr;
    logic [2:0]   hi;
    logic         pull;
    logic         active;
    logic         rstart_seen;
    logic         rw;
    int           seg_bits;   // scl rising edges since the last start

    // pull-up, either side may pull low
    assign sda_in = !(sda_oe || pull);

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = ERASED_BYTE;
        pull        = 1'b0;
        active      = 1'b0;
        rstart_seen = 1'b0;
        rw          = 1'b0;
        hi          = '0;
        seg_bits    = 0;
        proto_err   = 1'b0;
    end

    // start or repeated start
    always @(negedge sda_in)
    begin
        if (scl === 1'b1)
        begin
            if (active)
            begin
                if (seg_bits != 19 || rw)   // dummy write must be ctrl + addr
                    proto_err = 1'b1;
                rstart_seen = 1'b1;
            end
            else
                rstart_seen = 1'b0;
            active   = 1'b1;
            seg_bits = 0;
        end
    end

    // stop
    always @(posedge sda_in)
    begin
        if (scl === 1'b1 && active)
        begin
            if (rstart_seen)
            begin
                if (!rw || seg_bits != 19)
                    proto_err = 1'b1;
            end
            else if (rw || seg_bits != 28)
                proto_err = 1'b1;
            else
                mem[addr] = wdata;
            active = 1'b0;
            pull   = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (seg_bits % 9 < 8)
                shift = {shift[6:0], sda_in};
            if (seg_bits % 9 == 7)
            begin
                case (seg_bits / 9)
                    0:
                    begin
                        if (shift[7:4] != DEVICE_CODE)
                            proto_err = 1'b1;
                        if (rstart_seen)
                        begin
                            if (!shift[0] || shift[3:1] != hi)
                                proto_err = 1'b1;
                            rw = 1'b1;
                        end
                        else
                        begin
                            rw = shift[0];
                            hi = shift[3:1];
                            if (rw)   // no address set first
                                proto_err = 1'b1;
                        end
                    end
                    1: if (!rw) addr = {hi, shift};
                    2: if (!rw) wdata = shift;
                    default: proto_err = 1'b1;
                endcase
            end
            seg_bits++;
        end
    end

    // sda only moves while scl is low
    always @(negedge scl)
    begin
        if (active)
        begin
            if (seg_bits % 9 == 8 && !(rw && seg_bits / 9 == 1))
                pull = 1'b1;   // ack
            else if (rw && seg_bits >= 9 && seg_bits < 17)
                pull = ~mem[addr][16 - seg_bits];
            else
                pull = 1'b0;
        end
    end

endmodule

/* src/eeprom_sys_top.sv */
`timescale 1ns/1ps

module eeprom_sys_top import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         a_wr,
    input  logic         a_rd,
    input  eeprom_addr_t a_addr,
    input  eeprom_data_t a_wdata,
    output logic         a_done,
    output eeprom_data_t a_rdata,
    input  logic         b_wr,
    input  logic         b_rd,
    input  eeprom_addr_t b_addr,
    input  eeprom_data_t b_wdata,
    output logic         b_done,
    output eeprom_data_t b_rdata,
    output logic         scl,
    output logic         sda_oe,   // high pulls sda low
    input  logic         sda_in
);

    eeprom_req_if req_bus ();

    eeprom_arbiter u_arbiter
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .a_wr    (a_wr),
        .a_rd    (a_rd),
        .a_addr  (a_addr),
        .a_wdata (a_wdata),
        .a_done  (a_done),
        .a_rdata (a_rdata),
        .b_wr    (b_wr),
        .b_rd    (b_rd),
        .b_addr  (b_addr),
        .b_wdata (b_wdata),
        .b_done  (b_done),
        .b_rdata (b_rdata),
        .bus     (req_bus)
    );

    eeprom_serial_ctrl u_serial_ctrl
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .req    (req_bus),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

endmodule

/* src/eeprom_serial_ctrl.sv */
`timescale 1ns/1ps

module eeprom_serial_ctrl import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    eeprom_req_if.ctrl req,
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda_in
);

    ctrl_state_t  state;
    ctrl_state_t  next_byte;
    logic         ph;          // 0 = scl low half, 1 = scl high half
    logic [3:0]   bit_cnt;     // 0..7 data, 8 = ack slot
    eeprom_data_t shift;
    eeprom_addr_t addr_q;
    eeprom_data_t wdata_q;
    eeprom_data_t rdata_q;
    logic         is_rd;
    logic         done_q;
    logic         byte_state;
    logic         byte_done;
    logic         oe_d;

    assign byte_state = state inside {st_ctrl_wr, st_addr_wr, st_data_wr,
                                      st_ctrl_rd, st_data_rd};
    assign byte_done  = byte_state && ph && (bit_cnt == 4'd8);

    always_comb
    begin
        case (state)
            st_ctrl_wr: next_byte = st_addr_wr;
            st_addr_wr: next_byte = is_rd ? st_rstart : st_data_wr;
            st_ctrl_rd: next_byte = st_data_rd;
            default:    next_byte = st_stop;   // after data_wr or data_rd
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= st_idle;
            ph      <= 1'b0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (req.wr || req.rd)
                        state <= st_start;
                end
                st_start:
                begin
                    ph <= ~ph;
                    // r/w bit of the loaded control byte picks the branch
                    if (ph)
                        state <= shift[0] ? st_ctrl_rd : st_ctrl_wr;
                end
                st_rstart:
                    state <= st_start;
                st_stop:
                begin
                    ph <= ~ph;
                    if (ph)
                        bit_cnt <= 4'd1;
                    else if (bit_cnt == 4'd1)
                    begin
                        state   <= st_idle;
                        ph      <= 1'b0;
                        bit_cnt <= '0;
                        done_q  <= 1'b1;
                    end
                end
                default:
                begin
                    ph <= ~ph;
                    if (byte_done)
                    begin
                        bit_cnt <= '0;
                        state   <= next_byte;
                    end
                    else if (ph)
                        bit_cnt <= bit_cnt + 4'd1;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == st_idle && (req.wr || req.rd))
        begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            is_rd   <= req.rd;
            shift   <= {DEVICE_CODE, req.addr[10:8], 1'b0};
        end
        else if (byte_done && state == st_ctrl_wr)
            shift <= addr_q[7:0];
        else if (byte_done && state == st_addr_wr)
            shift <= is_rd ? {DEVICE_CODE, addr_q[10:8], 1'b1} : wdata_q;
        else if (byte_state && ph)
            shift <= {shift[6:0], 1'b0};   // msb first

        if (state == st_data_rd && ph && bit_cnt != 4'd8)
            rdata_q <= {rdata_q[6:0], sda_in};   // sampled while scl high
    end

    always_comb
    begin
        scl  = ph;
        oe_d = 1'b0;
        case (state)
            st_idle:
                scl = 1'b1;
            st_start:
            begin
                scl  = 1'b1;
                oe_d = ph;   // sda falls with scl high
            end
            st_rstart:
                scl = 1'b0;
            st_stop:
            begin
                scl  = ph || (bit_cnt != 4'd0);
                oe_d = (bit_cnt == 4'd0);   // released with scl high
            end
            st_data_rd:
                oe_d = 1'b0;   // slave drives, master nacks the ninth bit
            default:
                oe_d = (bit_cnt != 4'd8) && !shift[7];
        endcase
    end

    // half a clock after scl moves, keeps sda away from the scl edges
    always_ff @(negedge CLK)
    begin
        if (RESET)
            sda_oe <= 1'b0;
        else
            sda_oe <= oe_d;
    end

    assign req.done  = done_q;
    assign req.rdata = rdata_q;

endmodule

/* src/eeprom_arbiter.sv */
`timescale 1ns/1ps

module eeprom_arbiter import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         a_wr,
    input  logic         a_rd,
    input  eeprom_addr_t a_addr,
    input  eeprom_data_t a_wdata,
    output logic         a_done,
    output eeprom_data_t a_rdata,
    input  logic         b_wr,
    input  logic         b_rd,
    input  eeprom_addr_t b_addr,
    input  eeprom_data_t b_wdata,
    output logic         b_done,
    output eeprom_data_t b_rdata,
    eeprom_req_if.arb    bus
);

    logic [NUM_PORTS-1:0] in_wr;
    logic [NUM_PORTS-1:0] in_rd;
    logic [NUM_PORTS-1:0] accept;
    logic [NUM_PORTS-1:0] pend_valid;
    logic [NUM_PORTS-1:0] pend_rd;
    eeprom_addr_t         in_addr   [NUM_PORTS];
    eeprom_data_t         in_data   [NUM_PORTS];
    eeprom_addr_t         pend_addr [NUM_PORTS];
    eeprom_data_t         pend_data [NUM_PORTS];
    port_id_t             grant_port;   // owner of the current or last transaction
    port_id_t             win;
    logic                 busy;
    logic                 issue;

    assign in_wr      = {b_wr, a_wr};
    assign in_rd      = {b_rd, a_rd};
    assign in_addr[0] = a_addr;
    assign in_addr[1] = b_addr;
    assign in_data[0] = a_wdata;
    assign in_data[1] = b_wdata;

    // a second strobe while one is pending is dropped
    assign accept = (in_wr | in_rd) & ~pend_valid;

    // port not granted last goes first
    always_comb
    begin
        win = ~grant_port;
        if (!pend_valid[win])
            win = grant_port;
    end

    assign issue = !busy && (pend_valid != '0);

    assign bus.wr    = issue && !pend_rd[win];
    assign bus.rd    = issue && pend_rd[win];
    assign bus.addr  = pend_addr[win];
    assign bus.wdata = pend_data[win];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pend_valid <= '0;
            busy       <= 1'b0;
            grant_port <= 1'b1;   // so port a wins the first tie
        end
        else
        begin
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                if (accept[i])
                    pend_valid[i] <= 1'b1;
            end
            if (issue)
            begin
                pend_valid[win] <= 1'b0;
                busy            <= 1'b1;
                grant_port      <= win;
            end
            else if (bus.done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (accept[i])
            begin
                pend_rd[i]   <= in_rd[i];
                pend_addr[i] <= in_addr[i];
                pend_data[i] <= in_data[i];
            end
        end
    end

    assign a_done  = bus.done && (grant_port == 1'b0);
    assign b_done  = bus.done && (grant_port == 1'b1);
    assign a_rdata = (grant_port == 1'b0) ? bus.rdata : '0;
    assign b_rdata = (grant_port == 1'b1) ? bus.rdata : '0;

endmodule

/* src/eeprom_req_if.sv */
`timescale 1ns/1ps

interface eeprom_req_if import eeprom_pkg::*; ();

    logic         wr;      // one-cycle write strobe
    logic         rd;      // one-cycle read strobe
    eeprom_addr_t addr;
    eeprom_data_t wdata;
    logic         done;    // end of transaction
    eeprom_data_t rdata;   // valid with done on a read

    modport arb
    (
        output wr,
        output rd,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport ctrl
    (
        input  wr,
        input  rd,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

/* src/eeprom_pkg.sv */
package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t;   // byte address, 2 kbyte device
    typedef logic [7:0]  eeprom_data_t;
    typedef logic        port_id_t;       // 0 = port a, 1 = port b

    // serial master states
    typedef enum logic [3:0]
    {
        st_idle,
        st_start,
        st_ctrl_wr,
        st_addr_wr,
        st_data_wr,
        st_rstart,
        st_ctrl_rd,
        st_data_rd,
        st_stop
    } ctrl_state_t;

    localparam logic [3:0]   DEVICE_CODE = 4'b1010;  // control byte prefix
    localparam int           NUM_PORTS   = 2;
    localparam eeprom_data_t ERASED_BYTE = 8'hff;

endpackage
